// ==== include/fabric_params.svh ====
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// bus widths
`define BUS_AW 64
`define BUS_DW 64

// on-chip word RAM
`define RAM_BASE 32'h0000_1000
`define RAM_WORDS 3072

// SDRAM window, upper bound excluded
`define SDRAM_MIN 32'h8000_0000
`define SDRAM_MAX 32'h8080_0000

// halfword address width on the controller port
`define SDRAM_AW 22

// register addresses
`define KEY_ADDR 32'h1000_0000
`define UART_ADDR 32'h1000_0008

`endif

// ==== design/fabric_pkg.sv ====
`include "fabric_params.svh"

package fabric_pkg;

    // load/store kind as carried on bus_ls_type, stores use the low four
    typedef enum logic [2:0] {
        ls_lb  = 3'd0,
        ls_lh  = 3'd1,
        ls_lw  = 3'd2,
        ls_ld  = 3'd3,
        ls_lbu = 3'd4,
        ls_lhu = 3'd5,
        ls_lwu = 3'd6
    } ls_type_t;

    // decoded bus target
    typedef enum logic [2:0] {
        region_none  = 3'd0,
        region_ram   = 3'd1,
        region_sdram = 3'd2,
        region_key   = 3'd3,
        region_uart  = 3'd4
    } region_t;

    // raw value is already shifted down to bit 0
    function automatic logic [`BUS_DW-1:0] load_extend(input logic [`BUS_DW-1:0] raw,
                                                       input ls_type_t ls_type);
        logic [`BUS_DW-1:0] result;
        case (ls_type)
            ls_lb:   result = {{56{raw[7]}}, raw[7:0]};
            ls_lh:   result = {{48{raw[15]}}, raw[15:0]};
            ls_lw:   result = {{32{raw[31]}}, raw[31:0]};
            ls_lbu:  result = {56'd0, raw[7:0]};
            ls_lhu:  result = {48'd0, raw[15:0]};
            ls_lwu:  result = {32'd0, raw[31:0]};
            default: result = raw;
        endcase
        return result;
    endfunction

endpackage

// ==== design/address_decoder.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module address_decoder (
    input  logic [`BUS_AW-1:0] address,
    output fabric_pkg::region_t region
);
    import fabric_pkg::*;

    localparam logic [`BUS_AW-1:0] ram_lo = `BUS_AW'(`RAM_BASE);
    localparam logic [`BUS_AW-1:0] ram_hi = `BUS_AW'(`RAM_BASE + `RAM_WORDS * 4);
    localparam logic [`BUS_AW-1:0] sdram_lo = `BUS_AW'(`SDRAM_MIN);
    localparam logic [`BUS_AW-1:0] sdram_hi = `BUS_AW'(`SDRAM_MAX);

    always_comb begin
        region = region_none;
        if (address >= ram_lo && address < ram_hi) begin
            region = region_ram;
        end else if (address >= sdram_lo && address < sdram_hi) begin
            region = region_sdram;
        end else if (address == `BUS_AW'(`KEY_ADDR)) begin
            region = region_key;
        end else if (address == `BUS_AW'(`UART_ADDR)) begin
            region = region_uart;
        end
    end

endmodule

// ==== design/bus_control.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module bus_control (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                bus_read_enable,
    input  logic                bus_write_enable,
    input  fabric_pkg::region_t region,
    input  logic                ram_ack,
    input  logic [`BUS_DW-1:0]  ram_rdata,
    input  logic                sdram_ack,
    input  logic [`BUS_DW-1:0]  sdram_rdata,
    input  logic                mmio_ack,
    input  logic [`BUS_DW-1:0]  mmio_rdata,
    output logic                bus_read_done,
    output logic                bus_write_done,
    output logic [`BUS_DW-1:0]  bus_read_data,
    output logic                ram_start,
    output logic                sdram_start,
    output logic                mmio_start,
    output logic                access_write
);
    import fabric_pkg::*;

    logic busy;
    logic none_ack;
    logic any_ack;
    logic read_pending;
    logic write_pending;
    logic serve;

    // a transfer is served once the enable has dropped
    assign read_pending = !bus_read_enable && !bus_read_done;
    assign write_pending = !bus_write_enable && !bus_write_done;
    assign serve = (read_pending || write_pending) && !busy;
    assign any_ack = ram_ack || sdram_ack || mmio_ack || none_ack;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            busy <= 1'b0;
            none_ack <= 1'b0;
            ram_start <= 1'b0;
            sdram_start <= 1'b0;
            mmio_start <= 1'b0;
            access_write <= 1'b0;
        end else begin
            ram_start <= 1'b0;
            sdram_start <= 1'b0;
            mmio_start <= 1'b0;
            none_ack <= 1'b0;
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end
            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end
            if (serve) begin
                busy <= 1'b1;
                access_write <= !read_pending;
                case (region)
                    region_ram:   ram_start <= 1'b1;
                    region_sdram: sdram_start <= 1'b1;
                    region_key,
                    region_uart:  mmio_start <= 1'b1;
                    // unmapped, answer right away
                    default:      none_ack <= 1'b1;
                endcase
            end
            if (any_ack) begin
                busy <= 1'b0;
                if (access_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (any_ack && !access_write) begin
            if (ram_ack) begin
                bus_read_data <= ram_rdata;
            end else if (sdram_ack) begin
                bus_read_data <= sdram_rdata;
            end else if (mmio_ack) begin
                bus_read_data <= mmio_rdata;
            end else begin
                bus_read_data <= '0;
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
        else $error("bus_control: read and write enable both high");

    // targets only answer a start that was issued
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) any_ack |-> busy)
        else $error("bus_control: ack without a pending access");

endmodule

// ==== design/onchip_ram.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module onchip_ram (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 start,
    input  logic                 write,
    input  logic [`BUS_AW-1:0]   address,
    input  fabric_pkg::ls_type_t ls_type,
    input  logic [`BUS_DW-1:0]   write_data,
    output logic                 ack,
    output logic [`BUS_DW-1:0]   read_data
);
    import fabric_pkg::*;

    localparam int index_w = $clog2(`RAM_WORDS);

    logic [31:0] mem [`RAM_WORDS];
    logic [31:0] offset;
    logic [index_w-1:0] word_index;
    logic [1:0] size;
    // second word of a double
    logic upper_half;
    logic step;
    logic [31:0] lane_word;
    logic [2:0] align_mask;

    assign offset = address[31:0] - `RAM_BASE;
    assign word_index = offset[index_w+1:2] + index_w'(upper_half);
    assign size = ls_type[1:0];
    assign step = start || upper_half;
    assign lane_word = mem[word_index] >> {address[1:0], 3'b000};
    assign align_mask = {size == 2'd3, size[1], size != 2'd0};

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack <= 1'b0;
            upper_half <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (start && size == 2'd3) begin
                upper_half <= 1'b1;
            end else if (step) begin
                upper_half <= 1'b0;
                ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (step && write) begin
            case (size)
                2'd0:    mem[word_index][{address[1:0], 3'b000} +: 8] <= write_data[7:0];
                2'd1:    mem[word_index][{address[1], 4'b0000} +: 16] <= write_data[15:0];
                2'd2:    mem[word_index] <= write_data[31:0];
                default: mem[word_index] <= upper_half ? write_data[63:32] : write_data[31:0];
            endcase
        end
        if (step && !write) begin
            if (size != 2'd3) begin
                read_data <= load_extend({32'd0, lane_word}, ls_type);
            end else if (upper_half) begin
                read_data[63:32] <= mem[word_index];
            end else begin
                read_data[31:0] <= mem[word_index];
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        start |-> (address[2:0] & align_mask) == 3'b000)
        else $error("onchip_ram: misaligned access");

endmodule

// ==== design/sdram_bridge.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module sdram_bridge (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 start,
    input  logic                 write,
    input  logic [`BUS_AW-1:0]   address,
    input  fabric_pkg::ls_type_t ls_type,
    input  logic [`BUS_DW-1:0]   write_data,
    input  logic [15:0]          sdram_rddata,
    input  logic                 sdram_req_wait,
    output logic                 ack,
    output logic [`BUS_DW-1:0]   read_data,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]          sdram_wrdata,
    output logic [1:0]           sdram_byte_en,
    output logic                 sdram_read_en,
    output logic                 sdram_write_en
);
    import fabric_pkg::*;

    localparam int addr_w = `SDRAM_AW;

    logic [1:0] size;
    logic [1:0] beat;
    logic [1:0] last_beat;
    logic busy;
    logic beat_done;
    logic [`BUS_DW-1:0] read_buf;
    logic [`BUS_DW-1:0] assembled;

    // 1, 2 or 4 beats
    assign size = ls_type[1:0];
    assign last_beat = (size == 2'd3) ? 2'd3 : {1'b0, size == 2'd2};
    assign busy = sdram_read_en || sdram_write_en;
    assign beat_done = busy && !sdram_req_wait;

    // beat address and lanes follow the beat counter
    assign sdram_addr = address[addr_w:1] + addr_w'(beat);
    assign sdram_byte_en = (size == 2'd0) ? (address[0] ? 2'b10 : 2'b01) : 2'b11;
    assign sdram_wrdata = (size == 2'd0) ? {2{write_data[7:0]}}
                                         : write_data[{beat, 4'b0000} +: 16];

    // current beat merged into the halfwords read so far
    always_comb begin
        assembled = read_buf;
        assembled[{beat, 4'b0000} +: 16] = sdram_rddata;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sdram_read_en <= 1'b0;
            sdram_write_en <= 1'b0;
            beat <= 2'd0;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (start) begin
                sdram_read_en <= !write;
                sdram_write_en <= write;
            end else if (beat_done) begin
                if (beat == last_beat) begin
                    sdram_read_en <= 1'b0;
                    sdram_write_en <= 1'b0;
                    beat <= 2'd0;
                    ack <= 1'b1;
                end else begin
                    beat <= beat + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat_done && sdram_read_en) begin
            read_buf <= assembled;
            if (beat == last_beat) begin
                // odd byte sits in the upper lane
                read_data <= load_extend(assembled >> {address[0], 3'b000}, ls_type);
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) start |-> !busy)
        else $error("sdram_bridge: start during a transfer");

endmodule

// ==== design/mmio_regs.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module mmio_regs (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                start,
    input  logic                write,
    input  fabric_pkg::region_t region,
    input  logic [`BUS_DW-1:0]  write_data,
    input  logic [7:0]          key_ascii,
    input  logic                key_pressed,
    input  logic                interrupt_ack,
    output logic                ack,
    output logic [`BUS_DW-1:0]  read_data,
    output logic                uart_write,
    output logic [7:0]          uart_data,
    output logic                interrupt_vector
);
    import fabric_pkg::*;

    logic [7:0] key_code;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack <= 1'b0;
            uart_write <= 1'b0;
            interrupt_vector <= 1'b0;
            key_code <= 8'd0;
        end else begin
            ack <= start;
            uart_write <= start && write && region == region_uart;
            if (key_pressed) begin
                key_code <= key_ascii;
            end
            // ack wins over a key in the same cycle
            if (interrupt_ack) begin
                interrupt_vector <= 1'b0;
            end else if (key_pressed && key_ascii != 8'd0) begin
                interrupt_vector <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (start && write && region == region_uart) begin
            uart_data <= write_data[7:0];
        end
        if (start && !write) begin
            read_data <= (region == region_key) ? {56'd0, key_code} : '0;
        end
    end

endmodule

// ==== design/bus_fabric_top.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module bus_fabric_top (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic [`BUS_AW-1:0]   bus_address,
    input  logic [`BUS_DW-1:0]   bus_write_data,
    input  fabric_pkg::ls_type_t bus_ls_type,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    output logic [`BUS_DW-1:0]   bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]          sdram_wrdata,
    output logic [1:0]           sdram_byte_en,
    output logic                 sdram_read_en,
    output logic                 sdram_write_en,
    input  logic [15:0]          sdram_rddata,
    input  logic                 sdram_req_wait,
    input  logic [7:0]           key_ascii,
    input  logic                 key_pressed,
    input  logic                 interrupt_ack,
    output logic                 interrupt_vector,
    output logic                 uart_write,
    output logic [7:0]           uart_data
);
    import fabric_pkg::*;

    region_t region;
    logic ram_start;
    logic sdram_start;
    logic mmio_start;
    logic access_write;
    logic ram_ack;
    logic sdram_ack;
    logic mmio_ack;
    logic [`BUS_DW-1:0] ram_rdata;
    logic [`BUS_DW-1:0] sdram_rdata;
    logic [`BUS_DW-1:0] mmio_rdata;

    address_decoder u_decoder (
        .address (bus_address),
        .region  (region)
    );

    bus_control u_control (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .region           (region),
        .ram_ack          (ram_ack),
        .ram_rdata        (ram_rdata),
        .sdram_ack        (sdram_ack),
        .sdram_rdata      (sdram_rdata),
        .mmio_ack         (mmio_ack),
        .mmio_rdata       (mmio_rdata),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .bus_read_data    (bus_read_data),
        .ram_start        (ram_start),
        .sdram_start      (sdram_start),
        .mmio_start       (mmio_start),
        .access_write     (access_write)
    );

    onchip_ram u_ram (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .start      (ram_start),
        .write      (access_write),
        .address    (bus_address),
        .ls_type    (bus_ls_type),
        .write_data (bus_write_data),
        .ack        (ram_ack),
        .read_data  (ram_rdata)
    );

    sdram_bridge u_sdram (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .start          (sdram_start),
        .write          (access_write),
        .address        (bus_address),
        .ls_type        (bus_ls_type),
        .write_data     (bus_write_data),
        .sdram_rddata   (sdram_rddata),
        .sdram_req_wait (sdram_req_wait),
        .ack            (sdram_ack),
        .read_data      (sdram_rdata),
        .sdram_addr     (sdram_addr),
        .sdram_wrdata   (sdram_wrdata),
        .sdram_byte_en  (sdram_byte_en),
        .sdram_read_en  (sdram_read_en),
        .sdram_write_en (sdram_write_en)
    );

    mmio_regs u_mmio (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .start            (mmio_start),
        .write            (access_write),
        .region           (region),
        .write_data       (bus_write_data),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .interrupt_ack    (interrupt_ack),
        .ack              (mmio_ack),
        .read_data        (mmio_rdata),
        .uart_write       (uart_write),
        .uart_data        (uart_data),
        .interrupt_vector (interrupt_vector)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);
    // 40 ns period
    initial CLOCK_50 = 1'b0;
    always #20 CLOCK_50 = !CLOCK_50;

    initial begin
        KEY0 = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// ==== verification/bus_fabric_tb.sv ====
`timescale 1ns/1ps
`include "fabric_params.svh"

module bus_fabric_tb;
    import fabric_pkg::*;

    // roughly 120 bus transfers of up to 20 cycles each, plus margin
    localparam int cycle_limit = 4000;

    logic CLOCK_50;
    logic KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    ls_type_t bus_ls_type;
    logic bus_read_enable;
    logic bus_write_enable;
    logic [63:0] bus_read_data;
    logic bus_read_done;
    logic bus_write_done;
    logic [21:0] sdram_addr;
    logic [15:0] sdram_wrdata;
    logic [1:0] sdram_byte_en;
    logic sdram_read_en;
    logic sdram_write_en;
    logic [15:0] sdram_rddata;
    logic sdram_req_wait;
    logic [7:0] key_ascii;
    logic key_pressed;
    logic interrupt_ack;
    logic interrupt_vector;
    logic uart_write;
    logic [7:0] uart_data;

    int cycles;
    int errors;
    int tests_passed;
    int tests_failed;
    int uart_count;
    logic [7:0] uart_last;
    // expected memory contents by byte address
    logic [7:0] ref_bytes [bit [31:0]];
    // SDRAM model state
    logic [15:0] sdram_mem [bit [21:0]];
    int mem_version;
    logic [31:0] lcg_state;
    logic [1:0] wait_left;
    logic [1:0] wait_n;
    logic [15:0] merged;
    logic [21:0] beat_addr_q [$];
    logic [1:0] beat_be_q [$];

    tb_clock_gen u_clock_gen (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    bus_fabric_top DUT (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .sdram_addr       (sdram_addr),
        .sdram_wrdata     (sdram_wrdata),
        .sdram_byte_en    (sdram_byte_en),
        .sdram_read_en    (sdram_read_en),
        .sdram_write_en   (sdram_write_en),
        .sdram_rddata     (sdram_rddata),
        .sdram_req_wait   (sdram_req_wait),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .uart_write       (uart_write),
        .uart_data        (uart_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unwritten SDRAM halfwords
    function automatic logic [15:0] fill_half(input logic [21:0] a);
        return a[15:0] ^ {a[5:0], a[21:12]};
    endfunction

    function automatic logic [15:0] mem_read(input logic [21:0] a, input int version);
        if (sdram_mem.exists(a)) begin
            return sdram_mem[a];
        end
        return fill_half(a);
    endfunction

    // version forces a fresh read after a write
    assign sdram_rddata = mem_read(sdram_addr, mem_version);

    always @(posedge CLOCK_50) begin
        if (sdram_read_en || sdram_write_en) begin
            if (!sdram_req_wait) begin
                beat_addr_q.push_back(sdram_addr);
                beat_be_q.push_back(sdram_byte_en);
                if (sdram_write_en) begin
                    merged = mem_read(sdram_addr, mem_version);
                    if (sdram_byte_en[0]) merged[7:0] = sdram_wrdata[7:0];
                    if (sdram_byte_en[1]) merged[15:8] = sdram_wrdata[15:8];
                    sdram_mem[sdram_addr] = merged;
                    mem_version = mem_version + 1;
                end
                // next beat waits 0 to 3 cycles
                lcg_state = lcg_next(lcg_state);
                wait_n = lcg_state[17:16];
                sdram_req_wait <= (wait_n != 2'd0);
                wait_left <= wait_n;
            end else begin
                if (wait_left <= 2'd1) sdram_req_wait <= 1'b0;
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(negedge CLOCK_50) begin
        if (uart_write) begin
            uart_count = uart_count + 1;
            uart_last = uart_data;
        end
    end

    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error: %s = %h, expected %h", name, got, exp);
        errors = errors + 1;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed = tests_passed + 1;
            $display("test %s: pass", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: fail with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic bus_store(input logic [63:0] addr, input int t, input logic [63:0] data);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_ls_type <= ls_type_t'(t[2:0]);
        bus_write_data <= data;
        bus_write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        @(negedge CLOCK_50);
        // done drops on the edge that sees the enable
        if (bus_write_done !== 1'b0) begin
            report_mismatch("bus_write_done", 64'(bus_write_done), 64'd0);
        end
        while (!bus_write_done) @(negedge CLOCK_50);
    endtask

    task automatic bus_load(input logic [63:0] addr, input int t, output logic [63:0] data);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_ls_type <= ls_type_t'(t[2:0]);
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        @(negedge CLOCK_50);
        if (bus_read_done !== 1'b0) begin
            report_mismatch("bus_read_done", 64'(bus_read_done), 64'd0);
        end
        while (!bus_read_done) @(negedge CLOCK_50);
        data = bus_read_data;
    endtask

    task automatic ref_store(input logic [31:0] addr, input int t, input logic [63:0] data);
        int nbytes;
        nbytes = 1 << (t % 4);
        for (int i = 0; i < nbytes; i++) begin
            ref_bytes[addr + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [15:0] h;
        if (ref_bytes.exists(a)) begin
            return ref_bytes[a];
        end
        h = fill_half(a[22:1]);
        return a[0] ? h[15:8] : h[7:0];
    endfunction

    // RISC-V load rule, built from the width and signedness of the kind
    function automatic logic [63:0] expected_load(input logic [31:0] addr, input int t);
        int nbytes;
        logic [63:0] raw;
        logic [63:0] mask;
        logic sign;
        nbytes = 1 << (t % 4);
        raw = '0;
        for (int i = 0; i < nbytes; i++) begin
            raw[8*i +: 8] = ref_byte(addr + i);
        end
        if (nbytes == 8) return raw;
        mask = (64'd1 << (nbytes * 8)) - 64'd1;
        sign = raw[nbytes*8 - 1] && t < 4;
        return (raw & mask) | (sign ? ~mask : 64'd0);
    endfunction

    task automatic check_beats(input logic [31:0] addr, input int t);
        int nbeats;
        logic [21:0] exp_addr;
        logic [1:0] exp_be;
        nbeats = (t % 4 == 3) ? 4 : (t % 4 == 2) ? 2 : 1;
        exp_be = (t % 4 != 0) ? 2'b11 : (addr[0] ? 2'b10 : 2'b01);
        if (beat_addr_q.size() != nbeats) begin
            $display("SDRAM access at %h saw %0d beats instead of %0d",
                     addr, beat_addr_q.size(), nbeats);
            errors = errors + 1;
        end else begin
            for (int n = 0; n < nbeats; n++) begin
                exp_addr = addr[22:1] + 22'(n);
                if (beat_addr_q[n] !== exp_addr) begin
                    report_mismatch("sdram_addr", 64'(beat_addr_q[n]), 64'(exp_addr));
                end
                if (beat_be_q[n] !== exp_be) begin
                    report_mismatch("sdram_byte_en", 64'(beat_be_q[n]), 64'(exp_be));
                end
            end
        end
        beat_addr_q.delete();
        beat_be_q.delete();
    endtask

    task automatic store_both(input logic [31:0] addr, input int t, input logic [63:0] data,
                              input bit sdram);
        bus_store(64'(addr), t, data);
        ref_store(addr, t, data);
        if (sdram) check_beats(addr, t);
    endtask

    // every aligned load kind over 16 bytes
    task automatic load_all_kinds(input logic [31:0] base, input bit sdram);
        logic [63:0] got;
        logic [63:0] exp;
        for (int off = 0; off < 16; off++) begin
            for (int t = 0; t < 7; t++) begin
                if (off % (1 << (t % 4)) == 0) begin
                    bus_load(64'(base + off), t, got);
                    exp = expected_load(base + off, t);
                    if (got !== exp) report_mismatch("bus_read_data", got, exp);
                    if (sdram) check_beats(base + off, t);
                end
            end
        end
    endtask

    task automatic test_ram_round_trip();
        int e0;
        e0 = errors;
        store_both(32'h0000_1000, 3, 64'h8123_4567_89ab_cdef, 0);
        store_both(32'h0000_1008, 2, 64'h0000_0000_fedc_ba98, 0);
        store_both(32'h0000_100c, 1, 64'h0000_0000_0000_8001, 0);
        store_both(32'h0000_100e, 0, 64'h0000_0000_0000_009c, 0);
        store_both(32'h0000_100f, 0, 64'h0000_0000_0000_007f, 0);
        load_all_kinds(32'h0000_1000, 0);
        finish_test("ram_round_trip", e0);
    endtask

    task automatic test_sdram_round_trip();
        int e0;
        e0 = errors;
        beat_addr_q.delete();
        beat_be_q.delete();
        store_both(32'h8000_0100, 3, 64'hc0de_1234_f00d_8765, 1);
        store_both(32'h8000_0108, 2, 64'h0000_0000_9abc_7def, 1);
        store_both(32'h8000_010c, 0, 64'h0000_0000_0000_00a5, 1);
        store_both(32'h8000_010d, 0, 64'h0000_0000_0000_0042, 1);
        load_all_kinds(32'h8000_0100, 1);
        finish_test("sdram_round_trip", e0);
    endtask

    task automatic pulse_key(input logic [7:0] code);
        @(posedge CLOCK_50);
        key_ascii <= code;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    task automatic test_keyboard_interrupt();
        int e0;
        logic [63:0] got;
        e0 = errors;
        pulse_key(8'h41);
        if (interrupt_vector !== 1'b1) begin
            report_mismatch("interrupt_vector", 64'(interrupt_vector), 64'd1);
        end
        bus_load(64'(`KEY_ADDR), 2, got);
        if (got !== 64'h41) report_mismatch("bus_read_data", got, 64'h41);
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b1;
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b0;
        @(negedge CLOCK_50);
        if (interrupt_vector !== 1'b0) begin
            report_mismatch("interrupt_vector", 64'(interrupt_vector), 64'd0);
        end
        // zero code updates the register but raises nothing
        pulse_key(8'h00);
        if (interrupt_vector !== 1'b0) begin
            report_mismatch("interrupt_vector", 64'(interrupt_vector), 64'd0);
        end
        bus_load(64'(`KEY_ADDR), 6, got);
        if (got !== 64'h0) report_mismatch("bus_read_data", got, 64'h0);
        finish_test("keyboard_interrupt", e0);
    endtask

    task automatic test_console_write();
        int e0;
        e0 = errors;
        uart_count = 0;
        bus_store(64'(`UART_ADDR), 0, 64'h1122_3344_5566_775a);
        repeat (3) @(negedge CLOCK_50);
        if (uart_count != 1) begin
            $display("uart_write pulsed %0d times instead of once", uart_count);
            errors = errors + 1;
        end
        if (uart_last !== 8'h5a) report_mismatch("uart_data", 64'(uart_last), 64'h5a);
        finish_test("console_write", e0);
    endtask

    task automatic test_unmapped();
        int e0;
        logic [63:0] got;
        e0 = errors;
        beat_addr_q.delete();
        beat_be_q.delete();
        bus_load(64'h0000_0000_2000_0000, 3, got);
        if (got !== 64'h0) report_mismatch("bus_read_data", got, 64'h0);
        if (beat_addr_q.size() != 0) begin
            $display("SDRAM saw %0d beats during an unmapped access", beat_addr_q.size());
            errors = errors + 1;
        end
        if (sdram_read_en !== 1'b0 || sdram_write_en !== 1'b0) begin
            $display("SDRAM enable high after an unmapped access");
            errors = errors + 1;
        end
        finish_test("unmapped", e0);
    endtask

    initial begin
        cycles = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        uart_count = 0;
        uart_last = 8'h00;
        mem_version = 0;
        lcg_state = 32'h14a24199;
        wait_left = 2'd0;
        bus_address = '0;
        bus_write_data = '0;
        bus_ls_type = ls_lb;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        sdram_req_wait = 1'b0;
        key_ascii = 8'h00;
        key_pressed = 1'b0;
        interrupt_ack = 1'b0;
        wait (KEY0 === 1'b1);
        repeat (2) @(posedge CLOCK_50);
        test_ram_round_trip();
        test_sdram_round_trip();
        test_keyboard_interrupt();
        test_console_write();
        test_unmapped();
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
design/fabric_pkg.sv
design/address_decoder.sv
design/bus_control.sv
design/onchip_ram.sv
design/sdram_bridge.sv
design/mmio_regs.sv
design/bus_fabric_top.sv
verification/tb_clock_gen.sv
verification/bus_fabric_tb.sv

// ==== Makefile ====
TOP := bus_fabric_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
